// File: Makefile
# verilator build and run of the bram over uart testbench
TOP = bram_uart_top_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with verilator, run, and search sim.log for the pass message"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f bram_uart_top.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bram_pkg.sv
package bram_pkg;

	// uart timing, clock cycles per bit
	localparam int clks_per_bit = 8;
	// width of the per-bit cycle counter
	localparam int cnt_len = $clog2(clks_per_bit);

	// serial bus field widths
	localparam int addr_len = 12;
	localparam int data_len = 8;
	localparam int burst_len = 8;

	// ram size in bytes
	localparam int mem_depth = 4096;

	// three received bytes, first byte in the top bits
	// bit 23 write flag, 22:20 unused, 19:8 address, 7:0 data or burst
	typedef union packed {
		// write command, low byte is the data to store
		struct packed {
			logic                write;
			logic [2:0]          spare;
			logic [addr_len-1:0] addr;
			logic [data_len-1:0] data;
		} wr;
		// read command, low byte is burst length minus one
		struct packed {
			logic                 write;
			logic [2:0]           spare;
			logic [addr_len-1:0]  addr;
			logic [burst_len-1:0] burst;
		} rd;
	} cmd_word_u;

endpackage

// File: bram_slave.sv
module bram_slave (
	input  logic clk,
	input  logic reset,
	input  logic bus_master_valid,
	input  logic bus_write_en,
	input  logic bus_read_en,
	input  logic bus_addr,
	input  logic bus_wdata,
	input  logic bus_master_ready,
	output logic bus_rdata,
	output logic bus_slave_valid
);
	import bram_pkg::*;

	logic [3:0] hdr_cnt;
	// write goes into the ram next cycle
	logic wr_pend;
	// another read byte is due, waiting on ready
	logic rd_wait;
	logic [2:0] bit_cnt;
	logic [burst_len-1:0] bytes_left;
	logic [addr_len-1:0] addr_sh;
	logic [data_len-1:0] field_sh;
	logic [data_len-1:0] rd_sh;
	logic [data_len-1:0] mem [mem_depth];
	logic hdr_last;
	logic fetch;

	assign hdr_last = bus_master_valid && (hdr_cnt == 4'(addr_len - 1));
	assign fetch = rd_wait && bus_master_ready;
	assign bus_rdata = rd_sh[0];

	always_ff @(posedge clk) begin
		if (reset) begin
			hdr_cnt <= '0;
			wr_pend <= 1'b0;
			rd_wait <= 1'b0;
			bit_cnt <= '0;
			bytes_left <= '0;
			bus_slave_valid <= 1'b0;
		end else begin
			hdr_cnt <= bus_master_valid ? hdr_cnt + 1'b1 : 4'd0;
			wr_pend <= hdr_last && bus_write_en;
			if (hdr_last) begin
				rd_wait <= bus_read_en;
				// burst field already complete after eight bits
				bytes_left <= field_sh;
			end else if (fetch) begin
				rd_wait <= 1'b0;
				bus_slave_valid <= 1'b1;
				bit_cnt <= '0;
			end else if (bus_slave_valid) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 3'd7) begin
					// valid drops at least one cycle between bytes
					bus_slave_valid <= 1'b0;
					if (bytes_left != '0) begin
						bytes_left <= bytes_left - 1'b1;
						rd_wait <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus_master_valid) begin
			addr_sh <= {bus_addr, addr_sh[addr_len-1:1]};
			// only the first eight header bits carry the field
			if (hdr_cnt < 4'(data_len)) begin
				field_sh <= {bus_wdata, field_sh[data_len-1:1]};
			end
		end else if (fetch) begin
			// 12-bit address wraps 4095 to 0
			addr_sh <= addr_sh + 1'b1;
		end
		if (wr_pend) begin
			mem[addr_sh] <= field_sh;
		end
		if (fetch) begin
			rd_sh <= mem[addr_sh];
		end else if (bus_slave_valid) begin
			rd_sh <= {1'b0, rd_sh[data_len-1:1]};
		end
	end

endmodule

// File: bram_uart_top.f
bram_pkg.sv
uart_receiver.sv
command_assembler.sv
bus_master.sv
bram_slave.sv
uart_transmitter.sv
bram_uart_top.sv
uart_host_model.sv
bram_uart_top_tb.sv

// File: bram_uart_top.sv
module bram_uart_top (
	input  logic clk,
	input  logic reset,
	input  logic uart_rx,
	output logic uart_tx
);
	import bram_pkg::*;

	// receiver to assembler
	logic [data_len-1:0] rx_byte;
	logic rx_strobe;
	// assembler to master
	cmd_word_u cmd_word;
	logic cmd_valid;
	logic cmd_take;
	// serial bus
	logic bus_master_valid;
	logic bus_write_en;
	logic bus_read_en;
	logic bus_addr;
	logic bus_wdata;
	logic bus_master_ready;
	logic bus_rdata;
	logic bus_slave_valid;
	// master to transmitter
	logic [data_len-1:0] tx_byte;
	logic tx_strobe;
	logic tx_busy;

	uart_receiver uart_receiver_i (
		.clk(clk), .reset(reset), .rx(uart_rx), .rx_byte(rx_byte), .rx_strobe(rx_strobe)
	);

	command_assembler command_assembler_i (
		.clk(clk), .reset(reset), .rx_byte(rx_byte), .rx_strobe(rx_strobe),
		.cmd_take(cmd_take), .cmd_word(cmd_word), .cmd_valid(cmd_valid)
	);

	bus_master bus_master_i (
		.clk(clk), .reset(reset), .cmd_word(cmd_word), .cmd_valid(cmd_valid),
		.cmd_take(cmd_take), .bus_master_valid(bus_master_valid),
		.bus_write_en(bus_write_en), .bus_read_en(bus_read_en), .bus_addr(bus_addr),
		.bus_wdata(bus_wdata), .bus_master_ready(bus_master_ready), .bus_rdata(bus_rdata),
		.bus_slave_valid(bus_slave_valid), .tx_byte(tx_byte), .tx_busy(tx_busy),
		.tx_strobe(tx_strobe)
	);

	// single slave, no arbiter in between
	bram_slave bram_slave_i (
		.clk(clk), .reset(reset), .bus_master_valid(bus_master_valid),
		.bus_write_en(bus_write_en), .bus_read_en(bus_read_en), .bus_addr(bus_addr),
		.bus_wdata(bus_wdata), .bus_master_ready(bus_master_ready), .bus_rdata(bus_rdata),
		.bus_slave_valid(bus_slave_valid)
	);

	uart_transmitter uart_transmitter_i (
		.clk(clk), .reset(reset), .tx_byte(tx_byte), .tx_strobe(tx_strobe),
		.tx(uart_tx), .tx_busy(tx_busy)
	);

endmodule

// File: bram_uart_top_tb.sv
module bram_uart_top_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import bram_pkg::*;

	// frame counts over all tests, responses at their longest
	localparam int cmd_frames = 135;
	localparam int resp_frames = 172;
	localparam int frame_cycles = 10 * clks_per_bit;
	localparam int cycle_limit = 2 * (cmd_frames + resp_frames) * frame_cycles;

	logic clk;
	logic reset;
	logic uart_rx;
	logic uart_tx;

	// expected ram contents
	logic [data_len-1:0] ref_mem [mem_depth];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	// error count when the current test began
	int test_base = 0;

	bram_uart_top bram_uart_top_i (
		.clk(clk), .reset(reset), .uart_rx(uart_rx), .uart_tx(uart_tx)
	);

	uart_host_model host_i (
		.clk(clk), .reset(reset), .uart_tx(uart_tx), .uart_rx(uart_rx)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	task automatic write_byte(input int addr, input logic [data_len-1:0] data);
		logic [addr_len-1:0] a;
		a = addr_len'(addr % mem_depth);
		host_i.send_command(1'b1, a, data);
		ref_mem[a] = data;
	endtask

	// expects len bytes from consecutive addresses, wrapping at the top
	task automatic read_check(input int addr, input int len);
		logic [addr_len-1:0] a;
		logic [data_len-1:0] got;
		logic [data_len-1:0] exp;
		a = addr_len'(addr % mem_depth);
		host_i.send_command(1'b0, a, data_len'(len - 1));
		for (int k = 0; k < len; k++) begin
			while (host_i.rx_q.size() == 0) begin
				@(negedge clk);
			end
			got = host_i.rx_q.pop_front();
			exp = ref_mem[(addr + k) % mem_depth];
			checks++;
			assert (got == exp) else begin
				$display("CHECK FAILED at %0t ns: uart_tx byte expected 0x%02h got 0x%02h",
					$time, exp, got);
				errors++;
			end
		end
	endtask

	task automatic count_check(input int exp);
		checks++;
		assert (host_i.rx_count == exp) else begin
			$display("CHECK FAILED at %0t ns: received byte count expected %0d got %0d",
				$time, exp, host_i.rx_count);
			errors++;
		end
	endtask

	task automatic finish_test(input int num, input string name);
		$display("test %0d %s finished with %0d errors", num, name, errors - test_base);
		test_base = errors;
	endtask

	initial begin
		int base;
		int off;
		int len;
		int sum;
		int count0;
		reset = 1'b1;
		void'($urandom(13641));
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// idle line after reset
		repeat (200) begin
			@(negedge clk);
			checks++;
			assert (uart_tx === 1'b1) else begin
				$display("CHECK FAILED at %0t ns: uart_tx expected 1 got %b", $time, uart_tx);
				errors++;
			end
		end
		count_check(0);
		finish_test(1, "idle after reset");

		write_byte('h123, data_len'($urandom));
		read_check('h123, 1);
		// a lone write sends nothing back
		count0 = host_i.rx_count;
		write_byte('h7ff, data_len'($urandom));
		repeat (2 * frame_cycles) @(negedge clk);
		count_check(count0);
		finish_test(2, "write and single read");

		for (int i = 0; i < 6; i++) begin
			write_byte('h400 + i, data_len'($urandom));
		end
		read_check('h400, 6);
		finish_test(3, "burst of six");

		for (int i = 0; i < 4; i++) begin
			write_byte(mem_depth - 2 + i, data_len'($urandom));
		end
		read_check(mem_depth - 2, 4);
		finish_test(4, "burst across the top address");

		// read frames follow the write frames directly
		write_byte('h123, ~ref_mem['h123]);
		read_check('h123, 1);
		finish_test(5, "read right behind write");

		base = $urandom % mem_depth;
		for (int i = 0; i < 20; i++) begin
			write_byte(base + i, data_len'($urandom));
		end
		count0 = host_i.rx_count;
		sum = 0;
		for (int r = 0; r < 8; r++) begin
			off = $urandom % 20;
			len = 1 + $urandom % (20 - off);
			sum += len;
			read_check(base + off, len);
		end
		repeat (2 * frame_cycles) @(negedge clk);
		count_check(count0 + sum);
		finish_test(6, "random writes and reads");

		errors += host_i.frame_errors;
		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: bus_master.sv
module bus_master (
	input  logic                          clk,
	input  logic                          reset,
	input  bram_pkg::cmd_word_u           cmd_word,
	input  logic                          cmd_valid,
	output logic                          cmd_take,
	output logic                          bus_master_valid,
	output logic                          bus_write_en,
	output logic                          bus_read_en,
	output logic                          bus_addr,
	output logic                          bus_wdata,
	output logic                          bus_master_ready,
	input  logic                          bus_rdata,
	input  logic                          bus_slave_valid,
	output logic [bram_pkg::data_len-1:0] tx_byte,
	input  logic                          tx_busy,
	output logic                          tx_strobe
);
	import bram_pkg::*;

	logic in_header;
	logic in_read;
	logic is_write;
	logic [3:0] hdr_cnt;
	// bits of the current read byte
	logic [2:0] bit_cnt;
	logic [addr_len-1:0] addr_sh;
	logic [data_len-1:0] field_sh;
	// bytes still due after the current one
	logic [burst_len-1:0] burst_left;
	logic byte_done;

	assign cmd_take = cmd_valid && !in_header && !in_read;
	assign bus_master_valid = in_header;
	assign bus_write_en = in_header && is_write;
	assign bus_read_en = in_header && !is_write;
	assign bus_addr = addr_sh[0];
	assign bus_wdata = field_sh[0];
	// hold the slave while the uart is sending or a byte waits for it
	assign bus_master_ready = in_read && !tx_busy && !tx_strobe;
	assign byte_done = bus_slave_valid && (bit_cnt == 3'd7);

	always_ff @(posedge clk) begin
		if (reset) begin
			in_header <= 1'b0;
			in_read <= 1'b0;
			is_write <= 1'b0;
			hdr_cnt <= '0;
			bit_cnt <= '0;
			burst_left <= '0;
			tx_strobe <= 1'b0;
		end else begin
			tx_strobe <= byte_done;
			if (bus_slave_valid) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
			if (cmd_take) begin
				in_header <= 1'b1;
				hdr_cnt <= '0;
				is_write <= cmd_word.wr.write;
				burst_left <= cmd_word.rd.burst;
			end else if (in_header) begin
				hdr_cnt <= hdr_cnt + 1'b1;
				// twelve header cycles, one per address bit
				if (hdr_cnt == 4'(addr_len - 1)) begin
					in_header <= 1'b0;
					in_read <= !is_write;
				end
			end else if (in_read && tx_strobe) begin
				if (burst_left == '0) begin
					in_read <= 1'b0;
				end else begin
					burst_left <= burst_left - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_take) begin
			addr_sh <= cmd_word.wr.addr;
			// data or burst, the same low byte in both views
			field_sh <= cmd_word.wr.data;
		end else if (in_header) begin
			addr_sh <= {1'b0, addr_sh[addr_len-1:1]};
			field_sh <= {1'b0, field_sh[data_len-1:1]};
		end
		// read bytes come back lsb first
		if (bus_slave_valid) begin
			tx_byte <= {bus_rdata, tx_byte[data_len-1:1]};
		end
	end

endmodule

// File: command_assembler.sv
module command_assembler (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [bram_pkg::data_len-1:0] rx_byte,
	input  logic                          rx_strobe,
	input  logic                          cmd_take,
	output bram_pkg::cmd_word_u           cmd_word,
	output logic                          cmd_valid
);
	import bram_pkg::*;

	// bytes 0 and 1 of the command in progress
	logic [2*data_len-1:0] asm_sh;
	// index of the next byte expected
	logic [1:0] byte_cnt;
	// third byte arriving now
	logic last_byte;
	// holding word free, or freed this cycle
	logic load;

	assign last_byte = rx_strobe && (byte_cnt == 2'd2);
	assign load = last_byte && (!cmd_valid || cmd_take);

	always_ff @(posedge clk) begin
		if (reset) begin
			byte_cnt <= '0;
			cmd_valid <= 1'b0;
		end else begin
			// counter keeps running while a word is held
			if (rx_strobe) begin
				byte_cnt <= last_byte ? 2'd0 : byte_cnt + 1'b1;
			end
			if (load) begin
				cmd_valid <= 1'b1;
			end else if (cmd_take) begin
				cmd_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_strobe && !last_byte) begin
			asm_sh <= {asm_sh[data_len-1:0], rx_byte};
		end
		// a complete word with the holder still full is lost
		if (load) begin
			cmd_word <= {asm_sh, rx_byte};
		end
	end

endmodule

// File: uart_host_model.sv
module uart_host_model (
	input  logic clk,
	input  logic reset,
	input  logic uart_tx,
	output logic uart_rx
);
	timeunit 1ns;
	timeprecision 1ps;
	import bram_pkg::*;

	// bytes decoded from uart_tx, oldest first
	logic [data_len-1:0] rx_q [$];
	logic [data_len-1:0] rx_shift;
	int rx_count;
	int frame_errors;

	initial begin
		uart_rx = 1'b1;
		rx_count = 0;
		frame_errors = 0;
	end

	// start bit, data lsb first, stop bit
	task automatic send_byte(input logic [data_len-1:0] b);
		logic [data_len+1:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < data_len + 2; i++) begin
			@(posedge clk);
			uart_rx <= frame[i];
			repeat (clks_per_bit - 1) @(posedge clk);
		end
	endtask

	// three frames, no gap between them
	task automatic send_command(input logic write, input logic [addr_len-1:0] addr,
		input logic [data_len-1:0] field);
		send_byte({write, 3'b000, addr[addr_len-1:8]});
		send_byte(addr[7:0]);
		send_byte(field);
	endtask

	// sampled on the falling edge, where uart_tx is settled
	always begin
		@(negedge clk);
		if (!reset && uart_tx === 1'b0) begin
			// move to about mid start bit
			repeat (clks_per_bit / 2 - 1) @(negedge clk);
			for (int i = 0; i < data_len; i++) begin
				repeat (clks_per_bit) @(negedge clk);
				rx_shift = {uart_tx, rx_shift[data_len-1:1]};
			end
			repeat (clks_per_bit) @(negedge clk);
			if (uart_tx !== 1'b1) begin
				$display("host at %0t ns: frame on uart_tx has a low stop bit", $time);
				frame_errors++;
			end else begin
				rx_q.push_back(rx_shift);
				rx_count++;
			end
		end
	end

endmodule

// File: uart_receiver.sv
module uart_receiver (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          rx,
	output logic [bram_pkg::data_len-1:0] rx_byte,
	output logic                          rx_strobe
);
	import bram_pkg::*;

	// two flop synchronizer
	logic rx_s1;
	logic rx_s2;
	// frame in progress
	logic busy;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_idx;
	logic [cnt_len-1:0] cnt;
	// mid-bit sample point
	logic sample;

	assign sample = busy && (cnt == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
			busy <= 1'b0;
			bit_idx <= '0;
			cnt <= '0;
			rx_strobe <= 1'b0;
		end else begin
			rx_s1 <= rx;
			rx_s2 <= rx_s1;
			rx_strobe <= 1'b0;
			if (!busy) begin
				// falling edge, wait half a bit to reach mid start bit
				if (!rx_s2) begin
					busy <= 1'b1;
					bit_idx <= '0;
					cnt <= cnt_len'(clks_per_bit / 2 - 1);
				end
			end else if (!sample) begin
				cnt <= cnt - 1'b1;
			end else begin
				cnt <= cnt_len'(clks_per_bit - 1);
				bit_idx <= bit_idx + 1'b1;
				// glitch, line back high at mid start bit
				if (bit_idx == 4'd0 && rx_s2) begin
					busy <= 1'b0;
				end else if (bit_idx == 4'd9) begin
					busy <= 1'b0;
					// low stop bit drops the byte
					rx_strobe <= rx_s2;
				end
			end
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge clk) begin
		if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
			rx_byte <= {rx_s2, rx_byte[data_len-1:1]};
		end
	end

endmodule

// File: uart_transmitter.sv
module uart_transmitter (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [bram_pkg::data_len-1:0] tx_byte,
	input  logic                          tx_strobe,
	output logic                          tx,
	output logic                          tx_busy
);
	import bram_pkg::*;

	// stop, data, start, sent from bit 0 up
	logic [data_len+1:0] frame;
	logic [cnt_len-1:0] cnt;
	// bits after the one on the line
	logic [3:0] bits_left;
	logic bit_end;

	assign bit_end = tx_busy && (cnt == '0);
	// idle line is high
	assign tx = tx_busy ? frame[0] : 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_busy <= 1'b0;
			cnt <= '0;
			bits_left <= '0;
		end else if (!tx_busy) begin
			if (tx_strobe) begin
				tx_busy <= 1'b1;
				cnt <= cnt_len'(clks_per_bit - 1);
				bits_left <= 4'd9;
			end
		end else if (!bit_end) begin
			cnt <= cnt - 1'b1;
		end else begin
			cnt <= cnt_len'(clks_per_bit - 1);
			// stop bit done
			if (bits_left == '0) begin
				tx_busy <= 1'b0;
			end else begin
				bits_left <= bits_left - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tx_strobe && !tx_busy) begin
			frame <= {1'b1, tx_byte, 1'b0};
		end else if (bit_end) begin
			frame <= {1'b1, frame[data_len+1:1]};
		end
	end

endmodule
